//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

	// Data widths
	typedef logic [31:0] word;
	typedef logic [63:0] dword;

	localparam int numRegs = 16;

	// One bit per general register
	typedef logic [numRegs-1:0] regMask;

	typedef logic [4:0] aluOpCode;
	typedef logic [4:0] busSel;

	// Bus source numbers, lowest wins on a strobe clash
	localparam busSel srcR0 = 5'd0;
	localparam busSel srcHi = 5'd16;
	localparam busSel srcLo = 5'd17;
	localparam busSel srcZHigh = 5'd18;
	localparam busSel srcZLow = 5'd19;
	localparam busSel srcPc = 5'd20;
	localparam busSel srcMdr = 5'd21;
	localparam busSel srcInPort = 5'd22;
	localparam int numSources = 23;

	// ALU operation codes
	localparam aluOpCode opAdd = 5'd0;
	localparam aluOpCode opSub = 5'd1;
	localparam aluOpCode opAnd = 5'd2;
	localparam aluOpCode opOr = 5'd3;
	localparam aluOpCode opShr = 5'd4;
	localparam aluOpCode opShl = 5'd5;
	localparam aluOpCode opRor = 5'd6;
	localparam aluOpCode opRol = 5'd7;
	localparam aluOpCode opMul = 5'd8;
	localparam aluOpCode opDiv = 5'd9;
	localparam aluOpCode opNeg = 5'd10;
	localparam aluOpCode opNot = 5'd11;

endpackage

`default_nettype wire

//--- busMux.sv
`timescale 1ns/1ps
`default_nettype none

module busMux (
	input cpuPkg::regMask regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inPortOut,
	input cpuPkg::word regData [cpuPkg::numRegs],
	input cpuPkg::word hiData,
	input cpuPkg::word loData,
	input cpuPkg::word zHighData,
	input cpuPkg::word zLowData,
	input cpuPkg::word pcData,
	input cpuPkg::word mdrData,
	input cpuPkg::word inPortData,
	output cpuPkg::word busData
);

	logic [cpuPkg::numSources-1:0] outStrobes;
	cpuPkg::busSel sel;
	logic selValid;

	// Strobe bit position equals the source number
	assign outStrobes = {inPortOut, mdrOut, pcOut, zLowOut, zHighOut, loOut, hiOut, regOut};

	// Priority encoder, scanning down so the lowest number is kept
	always_comb begin
		sel = cpuPkg::srcR0;
		selValid = 1'b0;
		for (int i = cpuPkg::numSources - 1; i >= 0; i--) begin
			if (outStrobes[i]) begin
				sel = cpuPkg::busSel'(i);
				selValid = 1'b1;
			end
		end
	end

	always_comb begin
		busData = '0;
		if (selValid) begin
			case (sel)
				cpuPkg::srcHi: busData = hiData;
				cpuPkg::srcLo: busData = loData;
				cpuPkg::srcZHigh: busData = zHighData;
				cpuPkg::srcZLow: busData = zLowData;
				cpuPkg::srcPc: busData = pcData;
				cpuPkg::srcMdr: busData = mdrData;
				cpuPkg::srcInPort: busData = inPortData;
				// Sources 0 to 15 are the general registers
				default: busData = regData[sel[3:0]];
			endcase
		end
	end

	// Bus drivers must never contend
	always_comb begin
		assert final ($onehot0(outStrobes))
			else $error("busMux: more than one out strobe high (%b)", outStrobes);
	end

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
	input logic clk,
	input logic rstN,
	input cpuPkg::regMask regIn,
	input logic hiIn,
	input logic loIn,
	input cpuPkg::word busData,
	output cpuPkg::word regData [cpuPkg::numRegs],
	output cpuPkg::word hiData,
	output cpuPkg::word loData
);

	// General registers R0 to R15
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				regData[i] <= '0;
			end
		end else begin
			for (int i = 0; i < cpuPkg::numRegs; i++) begin
				if (regIn[i]) begin
					regData[i] <= busData;
				end
			end
		end
	end

	// HI and LO
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hiData <= '0;
			loData <= '0;
		end else begin
			if (hiIn) begin
				hiData <= busData;
			end
			if (loIn) begin
				loData <= busData;
			end
		end
	end

	// Load strobes stay quiet while reset is held
	assert property (@(posedge clk) !rstN |-> (regIn == '0))
		else $error("registerFile: regIn %h high during reset", regIn);

endmodule

`default_nettype wire

//--- aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
	input logic clk,
	input logic rstN,
	input logic yIn,
	input logic zIn,
	input cpuPkg::aluOpCode aluOp,
	input cpuPkg::word busData,
	output cpuPkg::word zHighData,
	output cpuPkg::word zLowData
);

	cpuPkg::word yData;
	cpuPkg::dword result;
	cpuPkg::dword rotWide;
	logic signed [63:0] mulA;
	logic signed [63:0] mulB;
	cpuPkg::word quotient;
	cpuPkg::word remainder;
	logic [4:0] shAmt;
	logic opKnown;

	// Operand A holding register
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			yData <= '0;
		end else if (yIn) begin
			yData <= busData;
		end
	end

	assign shAmt = busData[4:0];

	// Doubled word so rotates fall out of a plain shift
	assign rotWide = {yData, yData};

	// Sign extend first so the product keeps all 64 bits
	assign mulA = {{32{yData[31]}}, yData};
	assign mulB = {{32{busData[31]}}, busData};

	always_comb begin
		if (busData == '0) begin
			quotient = '1;
			remainder = yData;
		end else begin
			quotient = $signed(yData) / $signed(busData);
			remainder = $signed(yData) % $signed(busData);
		end
	end

	always_comb begin
		result = '0;
		opKnown = 1'b1;
		case (aluOp)
			cpuPkg::opAdd: result[31:0] = yData + busData;
			cpuPkg::opSub: result[31:0] = yData - busData;
			cpuPkg::opAnd: result[31:0] = yData & busData;
			cpuPkg::opOr: result[31:0] = yData | busData;
			cpuPkg::opShr: result[31:0] = yData >> shAmt;
			cpuPkg::opShl: result[31:0] = yData << shAmt;
			cpuPkg::opRor: result[31:0] = cpuPkg::word'(rotWide >> shAmt);
			// Left by n is right by 32 minus n
			cpuPkg::opRol: result[31:0] = cpuPkg::word'(rotWide >> (6'd32 - shAmt));
			cpuPkg::opMul: result = mulA * mulB;
			// Remainder high, quotient low
			cpuPkg::opDiv: result = {remainder, quotient};
			cpuPkg::opNeg: result[31:0] = '0 - yData;
			cpuPkg::opNot: result[31:0] = ~yData;
			default: opKnown = 1'b0;
		endcase
	end

	// Result pair loads together
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			zHighData <= '0;
			zLowData <= '0;
		end else if (zIn) begin
			zHighData <= result[63:32];
			zLowData <= result[31:0];
		end
	end

	assert property (@(posedge clk) disable iff (!rstN) zIn |-> opKnown)
		else $error("aluUnit: undefined aluOp %0d loaded into Z", aluOp);

endmodule

`default_nettype wire

//--- memoryDataReg.sv
`timescale 1ns/1ps
`default_nettype none

module memoryDataReg (
	input logic clk,
	input logic rstN,
	input logic mdrIn,
	input logic read,
	input cpuPkg::word busData,
	input cpuPkg::word memData,
	output cpuPkg::word mdrData
);

	cpuPkg::word mdrMux;

	// Memory side takes over on a read
	assign mdrMux = read ? memData : busData;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mdrData <= '0;
		end else if (mdrIn) begin
			mdrData <= mdrMux;
		end
	end

endmodule

`default_nettype wire

//--- programCounter.sv
`timescale 1ns/1ps
`default_nettype none

module programCounter (
	input logic clk,
	input logic rstN,
	input logic pcIn,
	input logic incPc,
	input cpuPkg::word busData,
	output cpuPkg::word pcData
);

	// Bus load has priority over increment
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcData <= '0;
		end else if (pcIn) begin
			pcData <= busData;
		end else if (incPc) begin
			pcData <= pcData + 32'd1;
		end
	end

endmodule

`default_nettype wire

//--- cpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath (
	input logic clk,
	input logic rstN,
	input cpuPkg::regMask regIn,
	input cpuPkg::regMask regOut,
	input logic hiIn,
	input logic loIn,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcIn,
	input logic pcOut,
	input logic incPc,
	input logic mdrIn,
	input logic mdrOut,
	input logic read,
	input logic yIn,
	input logic zIn,
	input logic irIn,
	input logic inPortOut,
	input cpuPkg::aluOpCode aluOp,
	input cpuPkg::word memData,
	input cpuPkg::word inPortData,
	output cpuPkg::word busData,
	output cpuPkg::word irData,
	output cpuPkg::word mdrData
);

	cpuPkg::word regData [cpuPkg::numRegs];
	cpuPkg::word hiData;
	cpuPkg::word loData;
	cpuPkg::word zHighData;
	cpuPkg::word zLowData;
	cpuPkg::word pcData;

	registerFile registerFile_inst (
		.clk(clk), .rstN(rstN), .regIn(regIn), .hiIn(hiIn), .loIn(loIn),
		.busData(busData), .regData(regData), .hiData(hiData), .loData(loData)
	);

	programCounter programCounter_inst (
		.clk(clk), .rstN(rstN), .pcIn(pcIn), .incPc(incPc),
		.busData(busData), .pcData(pcData)
	);

	memoryDataReg memoryDataReg_inst (
		.clk(clk), .rstN(rstN), .mdrIn(mdrIn), .read(read),
		.busData(busData), .memData(memData), .mdrData(mdrData)
	);

	aluUnit aluUnit_inst (
		.clk(clk), .rstN(rstN), .yIn(yIn), .zIn(zIn), .aluOp(aluOp),
		.busData(busData), .zHighData(zHighData), .zLowData(zLowData)
	);

	// Single shared bus
	busMux busMux_inst (
		.regOut(regOut), .hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut),
		.zLowOut(zLowOut), .pcOut(pcOut), .mdrOut(mdrOut), .inPortOut(inPortOut),
		.regData(regData), .hiData(hiData), .loData(loData), .zHighData(zHighData),
		.zLowData(zLowData), .pcData(pcData), .mdrData(mdrData),
		.inPortData(inPortData), .busData(busData)
	);

	// Instruction register, load only
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			irData <= '0;
		end else if (irIn) begin
			irData <= busData;
		end
	end

endmodule

`default_nettype wire

//--- tbCpuDatapath.sv
`timescale 1ns/1ps
`default_nettype none

module tbCpuDatapath;

	localparam int maxVectors = 256;
	localparam int fieldsPerLine = 5;
	localparam int resetCycles = 10;

	logic clk;
	logic rstN;
	cpuPkg::regMask regIn;
	cpuPkg::regMask regOut;
	logic hiIn;
	logic loIn;
	logic hiOut;
	logic loOut;
	logic zHighOut;
	logic zLowOut;
	logic pcIn;
	logic pcOut;
	logic incPc;
	logic mdrIn;
	logic mdrOut;
	logic read;
	logic yIn;
	logic zIn;
	logic irIn;
	logic inPortOut;
	cpuPkg::aluOpCode aluOp;
	cpuPkg::word memData;
	cpuPkg::word inPortData;
	cpuPkg::word busData;
	cpuPkg::word irData;
	cpuPkg::word mdrData;

	// Five fields per vector line: control, memData, inPortData, expected, flag
	logic [63:0] vectorMem [maxVectors * fieldsPerLine];
	int numVectors;
	int cycleCount;
	int cycleLimit;
	int errorCount;
	int checkCount;

	cpuDatapath cpuDatapath_inst (
		.clk(clk), .rstN(rstN), .regIn(regIn), .regOut(regOut), .hiIn(hiIn), .loIn(loIn),
		.hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut), .zLowOut(zLowOut), .pcIn(pcIn),
		.pcOut(pcOut), .incPc(incPc), .mdrIn(mdrIn), .mdrOut(mdrOut), .read(read),
		.yIn(yIn), .zIn(zIn), .irIn(irIn), .inPortOut(inPortOut), .aluOp(aluOp),
		.memData(memData), .inPortData(inPortData), .busData(busData), .irData(irData),
		.mdrData(mdrData)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run did not finish within %0d cycles", cycleLimit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Control word layout is aluOp[52:48], regIn[47:32], regOut[31:16], single strobes[15:0]
	task automatic applyVector(input int idx);
		logic [63:0] ctrl;
		ctrl = vectorMem[idx * fieldsPerLine];
		aluOp <= ctrl[52:48];
		regIn <= ctrl[47:32];
		regOut <= ctrl[31:16];
		hiIn <= ctrl[0];
		loIn <= ctrl[1];
		hiOut <= ctrl[2];
		loOut <= ctrl[3];
		zHighOut <= ctrl[4];
		zLowOut <= ctrl[5];
		pcIn <= ctrl[6];
		pcOut <= ctrl[7];
		incPc <= ctrl[8];
		mdrIn <= ctrl[9];
		mdrOut <= ctrl[10];
		read <= ctrl[11];
		yIn <= ctrl[12];
		zIn <= ctrl[13];
		irIn <= ctrl[14];
		inPortOut <= ctrl[15];
		memData <= vectorMem[idx * fieldsPerLine + 1][31:0];
		inPortData <= vectorMem[idx * fieldsPerLine + 2][31:0];
	endtask

	// Last vector slot is kept all zero
	task automatic driveIdle();
		applyVector(maxVectors - 1);
	endtask

	// Flag bit 0 checks busData, bit 1 checks irData against the same value
	task automatic checkOutputs(input int idx);
		cpuPkg::word expected;
		logic [63:0] flag;
		logic [63:0] ctrl;
		expected = vectorMem[idx * fieldsPerLine + 3][31:0];
		flag = vectorMem[idx * fieldsPerLine + 4];
		ctrl = vectorMem[idx * fieldsPerLine];
		if (flag[0]) begin
			checkCount++;
			if (busData !== expected) begin
				errorCount++;
				$display("Mismatch at %0t: busData expected %h, actual %h (vector %0d)",
					$time, expected, busData, idx);
			end
		end
		// MDR on the bus means its output port shows the same word
		if (flag[0] && ctrl[10]) begin
			checkCount++;
			if (mdrData !== expected) begin
				errorCount++;
				$display("Mismatch at %0t: mdrData expected %h, actual %h (vector %0d)",
					$time, expected, mdrData, idx);
			end
		end
		if (flag[1]) begin
			checkCount++;
			if (irData !== expected) begin
				errorCount++;
				$display("Mismatch at %0t: irData expected %h, actual %h (vector %0d)",
					$time, expected, irData, idx);
			end
		end
	endtask

	initial begin
		rstN = 1'b0;
		cycleCount = 0;
		errorCount = 0;
		checkCount = 0;
		numVectors = 0;
		// Unread entries stay all ones and mark the end
		for (int i = 0; i < maxVectors * fieldsPerLine; i++) begin
			vectorMem[i] = '1;
		end
		$readmemh("datapathVectors.txt", vectorMem);
		while (numVectors < maxVectors - 1 &&
				vectorMem[numVectors * fieldsPerLine + 4] != '1) begin
			numVectors++;
		end
		cycleLimit = numVectors + resetCycles + 50;
		for (int i = 0; i < fieldsPerLine; i++) begin
			vectorMem[(maxVectors - 1) * fieldsPerLine + i] = '0;
		end
		driveIdle();
		if (numVectors == 0) begin
			errorCount++;
			$display("No vectors could be read from datapathVectors.txt");
		end
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < numVectors; i++) begin
			@(posedge clk);
			applyVector(i);
			// Bus is settled by mid cycle
			@(negedge clk);
			checkOutputs(i);
		end
		@(posedge clk);
		driveIdle();
		$display("Errors: %0d in %0d checks over %0d vectors", errorCount, checkCount, numVectors);
		if (errorCount == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- datapathVectors.txt
// Columns: control memData inPortData expectedBus flag (flag 1 bus, 3 bus and IR)
// Control hex AA RRRR OOOO SSSS: aluOp, regIn, regOut, single strobes
// Strobe bits 0..15: hiIn loIn hiOut loOut zHighOut zLowOut pcIn pcOut
//                    incPc mdrIn mdrOut read yIn zIn irIn inPortOut
// Reset state
00000000010000 00000000 00000000 00000000 1
00000080000000 00000000 00000000 00000000 1
00000000000004 00000000 00000000 00000000 1
00000000000080 00000000 00000000 00000000 1
00000000000400 00000000 00000000 00000000 1
00000000000020 00000000 00000000 00000000 1
00000000000000 00000000 00000000 00000000 1
// Memory word through MDR, R3, HI and IR
00000000000A00 A5C31E7F 00000000 00000000 1
00000800000400 00000000 00000000 A5C31E7F 1
00000000084001 00000000 00000000 A5C31E7F 1
00000000000004 00000000 00000000 A5C31E7F 3
// Y from R3, then add sub and or neg not
00000000081000 00000000 00000000 A5C31E7F 1
0000000000A000 00000000 12345678 12345678 1
00000000000020 00000000 00000000 B7F774F7 1
00000000000010 00000000 00000000 00000000 1
0100000000A000 00000000 12345678 12345678 1
00000000000020 00000000 00000000 938EC807 1
0200000000A000 00000000 12345678 12345678 1
00000000000020 00000000 00000000 00001678 1
0300000000A000 00000000 12345678 12345678 1
00000000000020 00000000 00000000 B7F75E7F 1
0A00000000A000 00000000 12345678 12345678 1
00000000000020 00000000 00000000 5A3CE181 1
00000000000010 00000000 00000000 00000000 1
0B00000000A000 00000000 12345678 12345678 1
00000000000020 00000000 00000000 5A3CE180 1
// Shifts and rotates of 90000005 by 0, 1 and 31
00000000009000 00000000 90000005 90000005 1
0500000000A000 00000000 00000000 00000000 1
00000000000020 00000000 00000000 90000005 1
0500000000A000 00000000 00000001 00000001 1
00000000000020 00000000 00000000 2000000A 1
0500000000A000 00000000 0000001F 0000001F 1
00000000000020 00000000 00000000 80000000 1
0400000000A000 00000000 00000000 00000000 1
00000000000020 00000000 00000000 90000005 1
0400000000A000 00000000 00000001 00000001 1
00000000000020 00000000 00000000 48000002 1
0400000000A000 00000000 0000001F 0000001F 1
00000000000020 00000000 00000000 00000001 1
0600000000A000 00000000 00000000 00000000 1
00000000000020 00000000 00000000 90000005 1
0600000000A000 00000000 00000001 00000001 1
00000000000020 00000000 00000000 C8000002 1
0600000000A000 00000000 0000001F 0000001F 1
00000000000020 00000000 00000000 2000000B 1
0700000000A000 00000000 00000000 00000000 1
00000000000020 00000000 00000000 90000005 1
0700000000A000 00000000 00000001 00000001 1
00000000000020 00000000 00000000 2000000B 1
0700000000A000 00000000 0000001F 0000001F 1
00000000000020 00000000 00000000 C8000002 1
// Signed multiply and divide
00000000009000 00000000 FFFFFFFD FFFFFFFD 1
0800000000A000 00000000 40000001 40000001 1
00000000000020 00000000 00000000 3FFFFFFD 1
00000000000010 00000000 00000000 FFFFFFFF 1
0800000000A000 00000000 FFFFFFF0 FFFFFFF0 1
00000000000020 00000000 00000000 00000030 1
00000000000010 00000000 00000000 00000000 1
00000000009000 00000000 FFFFFF9C FFFFFF9C 1
0900000000A000 00000000 00000007 00000007 1
00000000000020 00000000 00000000 FFFFFFF2 1
00000000000010 00000000 00000000 FFFFFFFE 1
0900000000A000 00000000 00000000 00000000 1
00000000000020 00000000 00000000 FFFFFFFF 1
00000000000010 00000000 00000000 FFFFFF9C 1
// PC load, increment, and load winning over increment
00000000008040 00000000 00400100 00400100 1
00000000000180 00000000 00000000 00400100 1
00000000000180 00000000 00000000 00400101 1
00000000000180 00000000 00000000 00400102 1
00000000000080 00000000 00000000 00400103 1
00000000008140 00000000 0000ABCD 0000ABCD 1
00000000000080 00000000 00000000 0000ABCD 1

//--- verilog.f
cpuPkg.sv
busMux.sv
registerFile.sv
aluUnit.sv
memoryDataReg.sv
programCounter.sv
cpuDatapath.sv
tbCpuDatapath.sv

//--- Bender.yml
package:
  name: cpuDatapath

sources:
  - cpuPkg.sv
  - busMux.sv
  - registerFile.sv
  - aluUnit.sv
  - memoryDataReg.sv
  - programCounter.sv
  - cpuDatapath.sv
  - target: simulation
    files:
      - tbCpuDatapath.sv
